// File: hdl/issue_pkg.sv
package issue_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------

    // word counts, requests, credits and capacities
    localparam int cnt_w = 16;

    // ring address, at most 4096 slots
    localparam int addr_w = 12;

    localparam int index_w = 32;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [cnt_w-1:0]   cnt_t;
    typedef logic [addr_w-1:0]  addr_t;

    // running word sequence index
    typedef logic [index_w-1:0] index_t;

    // one released burst, as handed to the streamer
    typedef struct packed {
        addr_t  start_addr;
        cnt_t   length;
        index_t first_index;
    } burst_desc_t;

    // ----------------------------------------
    // defaults
    // ----------------------------------------

    // ring size when the top level is not told otherwise
    localparam int default_buf_depth = 256;

endpackage

// File: hdl/burst_if.sv
`timescale 1ns/10ps

// burst descriptor channel, valid/ready
interface burst_if
    import issue_pkg::*;
();

    burst_desc_t desc;
    logic        valid;
    logic        ready;

    // address generator side
    modport source (
        output desc,
        output valid,
        input  ready
    );

    // word streamer side
    modport sink (
        input  desc,
        input  valid,
        output ready
    );

endinterface

// File: hdl/capacity_control.sv
`timescale 1ns/10ps

module capacity_control
    import issue_pkg::*;
#(
    parameter cnt_t INIT_CAPACITY = cnt_t'(default_buf_depth)
) (
    input  logic clk,
    input  logic reset,

    // run-time burst limit
    input  cnt_t max_issue,

    input  cnt_t req_len,
    input  logic req_valid,
    input  cnt_t credit_count,
    input  logic credit_valid,

    output cnt_t issue_size,
    output logic issue_valid,
    input  logic issue_ready,

    output cnt_t current_capacity,
    output cnt_t queued_request
);

    // inputs that arrived while the issue register was busy
    cnt_t req_acc;
    cnt_t credit_acc;

    cnt_t queued_q;
    cnt_t capacity_q;

    cnt_t issue_size_q;
    logic issue_valid_q;

    logic accept;
    logic fold;
    cnt_t accepted_size;
    cnt_t pending_min;
    cnt_t next_size;

    // ----------------------------------------
    // handshake
    // ----------------------------------------

    assign accept = issue_valid_q && issue_ready;

    // totals move on acceptance or while the register is empty
    assign fold = accept || !issue_valid_q;

    assign accepted_size = accept ? issue_size_q : '0;

    // smallest of pending words, free slots and the limit
    assign pending_min = (queued_q <= capacity_q) ? queued_q : capacity_q;
    assign next_size   = (pending_min <= max_issue) ? pending_min : max_issue;

    // ----------------------------------------
    // accumulators and totals
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            req_acc    <= '0;
            credit_acc <= '0;
            queued_q   <= '0;
            capacity_q <= INIT_CAPACITY;
        end else begin
            req_acc    <= (fold ? cnt_t'(0) : req_acc) + (req_valid ? req_len : cnt_t'(0));
            credit_acc <= (fold ? cnt_t'(0) : credit_acc)
                        + (credit_valid ? credit_count : cnt_t'(0));

            if (fold) begin
                queued_q   <= queued_q + req_acc - accepted_size;
                capacity_q <= capacity_q + credit_acc - accepted_size;
            end
        end
    end

    // ----------------------------------------
    // issue register
    // ----------------------------------------

    // loads only when empty, so the accepted size has
    // already left the totals it is computed from
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_size_q  <= '0;
            issue_valid_q <= 1'b0;
        end else if (accept) begin
            issue_valid_q <= 1'b0;
        end else if (!issue_valid_q) begin
            issue_size_q  <= next_size;
            issue_valid_q <= (queued_q != '0) && (capacity_q != '0);
        end
    end

    assign issue_size  = issue_size_q;
    assign issue_valid = issue_valid_q;

    assign current_capacity = capacity_q;
    assign queued_request   = queued_q;

endmodule

// File: hdl/burst_addr_gen.sv
`timescale 1ns/10ps

module burst_addr_gen
    import issue_pkg::*;
#(
    parameter int BUF_DEPTH = default_buf_depth
) (
    input  logic clk,
    input  logic reset,

    input  cnt_t issue_size,
    input  logic issue_valid,
    output logic issue_ready,

    burst_if.source desc
);

    // ring is a power of two, so wrapping is a mask
    localparam addr_t RING_MASK = addr_t'(BUF_DEPTH - 1);

    addr_t       next_addr;
    index_t      next_index;
    burst_desc_t desc_q;
    logic        desc_valid_q;
    logic        issue_fire;

    // single descriptor slot
    assign issue_ready = !desc_valid_q || desc.ready;
    assign issue_fire  = issue_valid && issue_ready;

    // ----------------------------------------
    // ring position and sequence index
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            next_addr  <= '0;
            next_index <= '0;
        end else if (issue_fire) begin
            next_addr  <= (next_addr + addr_t'(issue_size)) & RING_MASK;
            next_index <= next_index + index_t'(issue_size);
        end
    end

    // ----------------------------------------
    // descriptor register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            desc_valid_q <= 1'b0;
        end else if (issue_fire) begin
            desc_valid_q <= 1'b1;
        end else if (desc.ready) begin
            desc_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            desc_q.start_addr  <= next_addr;
            desc_q.length      <= issue_size;
            desc_q.first_index <= next_index;
        end
    end

    assign desc.desc  = desc_q;
    assign desc.valid = desc_valid_q;

endmodule

// File: hdl/word_streamer.sv
`timescale 1ns/10ps

module word_streamer
    import issue_pkg::*;
(
    input  logic clk,
    input  logic reset,

    burst_if.sink desc,

    // ring size minus one, from the top level
    input  addr_t addr_mask,

    output logic   out_valid,
    output addr_t  out_addr,
    output index_t out_index
);

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t state;
    cnt_t   remaining;
    addr_t  cur_addr;
    index_t cur_index;
    logic   load;

    // no new descriptor while a burst is being expanded
    assign desc.ready = (state == ST_IDLE);
    assign load       = desc.valid && desc.ready;

    // ----------------------------------------
    // FSM
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // zero-length bursts are dropped
                    if (load && desc.desc.length != '0) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (remaining == cnt_t'(1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // word counters
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (load) begin
            remaining <= desc.desc.length;
            cur_addr  <= desc.desc.start_addr;
            cur_index <= desc.desc.first_index;
        end else if (state == ST_STREAM) begin
            remaining <= remaining - cnt_t'(1);
            cur_addr  <= (cur_addr + addr_t'(1)) & addr_mask;
            cur_index <= cur_index + index_t'(1);
        end
    end

    assign out_valid = (state == ST_STREAM);
    assign out_addr  = cur_addr;
    assign out_index = cur_index;

endmodule

// File: hdl/buffered_issue_top.sv
`timescale 1ns/10ps

module buffered_issue_top
    import issue_pkg::*;
#(
    // power of two, at most 4096
    parameter int BUF_DEPTH = default_buf_depth
) (
    input  logic   clk,
    input  logic   reset,

    input  cnt_t   max_issue,

    // client requests
    input  cnt_t   req_len,
    input  logic   req_valid,

    // slots handed back by the consumer
    input  cnt_t   credit_count,
    input  logic   credit_valid,

    // words toward the consumer, one per cycle
    output logic   out_valid,
    output addr_t  out_addr,
    output index_t out_index,

    output cnt_t   current_capacity,
    output cnt_t   queued_request
);

    localparam addr_t ADDR_MASK = addr_t'(BUF_DEPTH - 1);

    cnt_t issue_size;
    logic issue_valid;
    logic issue_ready;

    burst_if burst ();

    // ----------------------------------------
    // stages
    // ----------------------------------------

    capacity_control #(
        .INIT_CAPACITY (cnt_t'(BUF_DEPTH))
    ) u_capacity_control (
        .clk              (clk),
        .reset            (reset),
        .max_issue        (max_issue),
        .req_len          (req_len),
        .req_valid        (req_valid),
        .credit_count     (credit_count),
        .credit_valid     (credit_valid),
        .issue_size       (issue_size),
        .issue_valid      (issue_valid),
        .issue_ready      (issue_ready),
        .current_capacity (current_capacity),
        .queued_request   (queued_request)
    );

    burst_addr_gen #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_burst_addr_gen (
        .clk         (clk),
        .reset       (reset),
        .issue_size  (issue_size),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .desc        (burst.source)
    );

    word_streamer u_word_streamer (
        .clk       (clk),
        .reset     (reset),
        .desc      (burst.sink),
        .addr_mask (ADDR_MASK),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_index (out_index)
    );

endmodule

// File: test/buffered_issue_asserts.sv
`timescale 1ns/10ps

// burst size and handshake rules on the capacity control issue port
module buffered_issue_asserts
    import issue_pkg::*;
(
    input logic clk,
    input logic reset,
    input cnt_t max_issue,
    input cnt_t issue_size,
    input logic issue_valid,
    input logic issue_ready,
    input cnt_t current_capacity
);

    // ----------------------------------------
    // burst size
    // ----------------------------------------

    size_within_limit: assert property (
        @(posedge clk) disable iff (reset)
        issue_valid |-> issue_size <= max_issue
    ) else $error("issue_size %h above max_issue %h", issue_size, max_issue);

    size_within_capacity: assert property (
        @(posedge clk) disable iff (reset)
        issue_valid |-> issue_size <= current_capacity
    ) else $error("issue_size %h above current_capacity %h", issue_size, current_capacity);

    // ----------------------------------------
    // valid/ready hold
    // ----------------------------------------

    valid_held: assert property (
        @(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid
    ) else $error("issue_valid dropped before issue_ready");

    size_held: assert property (
        @(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> $stable(issue_size)
    ) else $error("issue_size changed while issue_ready was low");

endmodule

bind capacity_control buffered_issue_asserts u_asserts (
    .clk              (clk),
    .reset            (reset),
    .max_issue        (max_issue),
    .issue_size       (issue_size),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .current_capacity (current_capacity)
);

// File: test/tb_buffered_issue.sv
`timescale 1ns/10ps

module tb_buffered_issue
    import issue_pkg::*;
();

    localparam int BUF_DEPTH    = 16;
    localparam int NUM_ROWS     = 9;
    localparam int WORD_TIMEOUT = 400;
    localparam int QUIET_CYCLES = 12;

    // one row: request length, burst limit, credits handed back
    typedef struct packed {
        cnt_t req;
        cnt_t max_issue;
        cnt_t credits;
    } row_t;

    logic   clk;
    logic   reset;
    cnt_t   max_issue;
    cnt_t   req_len;
    logic   req_valid;
    cnt_t   credit_count;
    logic   credit_valid;
    logic   out_valid;
    addr_t  out_addr;
    index_t out_index;
    cnt_t   current_capacity;
    cnt_t   queued_request;

    row_t   rows [NUM_ROWS];

    // reference model state
    index_t exp_index;
    int     emitted_total;
    int     requested_total;
    int     credit_total;
    int     model_queued;
    int     model_cap;
    int     phase_words;

    int     check_cnt;
    int     error_cnt;
    int     test_cnt;

    buffered_issue_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) UUT (
        .clk              (clk),
        .reset            (reset),
        .max_issue        (max_issue),
        .req_len          (req_len),
        .req_valid        (req_valid),
        .credit_count     (credit_count),
        .credit_valid     (credit_valid),
        .out_valid        (out_valid),
        .out_addr         (out_addr),
        .out_index        (out_index),
        .current_capacity (current_capacity),
        .queued_request   (queued_request)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_count(input string name, input cnt_t actual, input cnt_t expected);
        check_cnt++;
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            error_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        check_cnt++;
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            error_cnt++;
        end
    endtask

    task automatic check_index(input string name, input index_t actual, input index_t expected);
        check_cnt++;
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            error_cnt++;
        end
    endtask

    function automatic int min_count(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // ----------------------------------------
    // cycle helpers
    // ----------------------------------------

    // advance to the falling edge and check any word on the output
    task automatic step_cycle();
        @(negedge clk);
        if (out_valid) begin
            check_index("out_index", out_index, exp_index);
            check_addr("out_addr", out_addr, addr_t'(exp_index % BUF_DEPTH));
            exp_index = exp_index + index_t'(1);
            emitted_total++;
            phase_words++;
        end
    endtask

    task automatic wait_words(input int target, input int row);
        int waited;
        waited = 0;
        while (phase_words < target && waited < WORD_TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (phase_words < target) begin
            $display("Timeout on row %0d: only %0d of %0d words arrived", row, phase_words,
                     target);
            error_cnt++;
        end
    endtask

    task automatic load_table();
        // long request with no credits drains the whole ring
        rows[0] = '{cnt_t'(20), cnt_t'(4),  cnt_t'(0)};
        rows[1] = '{cnt_t'(3),  cnt_t'(1),  cnt_t'(10)};
        rows[2] = '{cnt_t'(5),  cnt_t'(3),  cnt_t'(8)};
        rows[3] = '{cnt_t'(6),  cnt_t'(16), cnt_t'(12)};
        rows[4] = '{cnt_t'(9),  cnt_t'(2),  cnt_t'(9)};
        rows[5] = '{cnt_t'(40), cnt_t'(16), cnt_t'(16)};
        rows[6] = '{cnt_t'(1),  cnt_t'(1),  cnt_t'(14)};
        rows[7] = '{cnt_t'(16), cnt_t'(5),  cnt_t'(1)};
        rows[8] = '{cnt_t'(0),  cnt_t'(3),  cnt_t'(16)};
    endtask

    task automatic run_row(input int row);
        int n1;
        int n2;
        int delay;
        int errors_before;
        errors_before = error_cnt;
        phase_words   = 0;

        max_issue = rows[row].max_issue;
        step_cycle();
        req_len   = rows[row].req;
        req_valid = 1'b1;
        step_cycle();
        req_valid = 1'b0;
        req_len   = '0;
        requested_total += int'(rows[row].req);
        model_queued    += int'(rows[row].req);

        // words the free slots allow before any credit comes back
        n1 = min_count(model_queued, model_cap);
        wait_words(n1, row);
        model_queued -= n1;
        model_cap    -= n1;

        delay = $urandom % 8;
        repeat (delay) step_cycle();
        step_cycle();
        credit_count = rows[row].credits;
        credit_valid = 1'b1;
        step_cycle();
        credit_valid = 1'b0;
        credit_count = '0;
        credit_total += int'(rows[row].credits);
        model_cap    += int'(rows[row].credits);

        n2 = min_count(model_queued, model_cap);
        wait_words(n1 + n2, row);
        model_queued -= n2;
        model_cap    -= n2;

        // nothing more may follow
        repeat (QUIET_CYCLES) step_cycle();
        if (phase_words != n1 + n2) begin
            $display("Row %0d delivered %0d words where %0d were expected", row, phase_words,
                     n1 + n2);
            error_cnt++;
        end

        check_count("queued_request", queued_request, cnt_t'(requested_total - emitted_total));
        check_count("current_capacity", current_capacity,
                    cnt_t'(BUF_DEPTH + credit_total - emitted_total));

        test_cnt++;
        $display("row %0d: req %0d, max_issue %0d, credits %0d, words %0d, %s", row,
                 rows[row].req, rows[row].max_issue, rows[row].credits, phase_words,
                 (error_cnt == errors_before) ? "ok" : "FAILED");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        int errors_before;

        max_issue    = cnt_t'(4);
        req_len      = '0;
        req_valid    = 1'b0;
        credit_count = '0;
        credit_valid = 1'b0;
        reset        = 1'b1;

        exp_index       = '0;
        emitted_total   = 0;
        requested_total = 0;
        credit_total    = 0;
        model_queued    = 0;
        model_cap       = BUF_DEPTH;
        phase_words     = 0;
        check_cnt       = 0;
        error_cnt       = 0;
        test_cnt        = 0;

        void'($urandom(58796));
        load_table();

        repeat (10) @(negedge clk);
        reset = 1'b0;

        // state right after reset
        errors_before = error_cnt;
        @(negedge clk);
        check_cnt++;
        if (out_valid) begin
            $display("out_valid is high right after reset");
            error_cnt++;
        end
        check_count("current_capacity", current_capacity, cnt_t'(BUF_DEPTH));
        check_count("queued_request", queued_request, cnt_t'(0));
        test_cnt++;
        $display("reset state: %s", (error_cnt == errors_before) ? "ok" : "FAILED");

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/issue_pkg.sv
hdl/burst_if.sv
hdl/capacity_control.sv
hdl/burst_addr_gen.sv
hdl/word_streamer.sv
hdl/buffered_issue_top.sv
test/buffered_issue_asserts.sv
test/tb_buffered_issue.sv

// File: Bender.yml
package:
  name: buffered_issue

sources:
  - hdl/issue_pkg.sv
  - hdl/burst_if.sv
  - hdl/capacity_control.sv
  - hdl/burst_addr_gen.sv
  - hdl/word_streamer.sv
  - hdl/buffered_issue_top.sv
  - target: test
    files:
      - test/buffered_issue_asserts.sv
      - test/tb_buffered_issue.sv
